//--- list.f
rtl/axi_fifo_pkg.sv
rtl/beat_fifo.sv
rtl/aw_release.sv
rtl/ar_reserve.sv
rtl/axi_fifo.sv
sim/axi_fifo_assertions.sv
sim/tb_axi_fifo.sv

//--- Makefile
# Verilator build and run of the AXI4 burst buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_fifo
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_axi_fifo.sv
`timescale 1ns/1ns

// tb_axi_fifo
// directed tests for the AXI4 burst buffer, both data FIFOs 8 deep
// upstream manager and downstream subordinate are modeled here
module tb_axi_fifo;

    import axi_fifo_pkg::*;

    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 400;
    localparam int RD_LEN  = 5;
    localparam int RD_HOLD = 24;

    logic clk;
    logic rst;

    axi_id_t   s_awid, m_awid, s_arid, m_arid, s_bid, m_bid, s_rid, m_rid;
    axi_addr_t s_awaddr, m_awaddr, s_araddr, m_araddr;
    axi_len_t  s_awlen, m_awlen, s_arlen, m_arlen;
    axi_data_t s_wdata, m_wdata, s_rdata, m_rdata;
    axi_strb_t s_wstrb, m_wstrb;
    axi_resp_t s_bresp, m_bresp, s_rresp, m_rresp;
    logic      s_wlast, m_wlast, s_rlast, m_rlast;
    logic      s_awvalid, s_awready, m_awvalid, m_awready;
    logic      s_wvalid, s_wready, m_wvalid, m_wready;
    logic      s_bvalid, s_bready, m_bvalid, m_bready;
    logic      s_arvalid, s_arready, m_arvalid, m_arready;
    logic      s_rvalid, s_rready, m_rvalid, m_rready;

    int errors;
    int checks;
    int violations;

    axi_fifo #(
        .WRITE_FIFO_DEPTH(DEPTH),
        .READ_FIFO_DEPTH (DEPTH)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // beat i of a write burst as the manager sends it
    function automatic w_beat_t w_pattern(axi_addr_t addr, int i, axi_len_t len);
        w_beat_t b;
        b.data = addr ^ (32'h0101_0101 * 32'(i + 1));
        b.strb = STRB_W'(i * 5 + 3);
        b.last = (i == int'(len));
        return b;
    endfunction

    // beat i of read burst k as the subordinate returns it
    function automatic r_beat_t r_pattern(int k, int i);
        r_beat_t b;
        b.data = 32'hd000_0000 + 32'(k * 256 + i);
        b.last = (i == RD_LEN);
        b.id   = ID_W'(64 + k);
        b.resp = RESP_W'(i + k);
        return b;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic check_reset();
        @(posedge clk);
        check_value("s_awready", 64'(s_awready), 64'd0);
        check_value("m_awvalid", 64'(m_awvalid), 64'd0);
        check_value("m_wvalid", 64'(m_wvalid), 64'd0);
        check_value("s_arready", 64'(s_arready), 64'd0);
        check_value("m_arvalid", 64'(m_arvalid), 64'd0);
        check_value("s_rvalid", 64'(s_rvalid), 64'd0);
    endtask

    task automatic drive_write(axi_id_t id, axi_addr_t addr, axi_len_t len);
        w_beat_t b;
        int t;
        s_awid    <= id;
        s_awaddr  <= addr;
        s_awlen   <= len;
        s_awvalid <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!s_awready && t < TIMEOUT);
        if (!s_awready) report_timeout("s_awready");
        s_awvalid <= 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            b = w_pattern(addr, i, len);
            s_wdata  <= b.data;
            s_wstrb  <= b.strb;
            s_wlast  <= b.last;
            s_wvalid <= 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!s_wready && t < TIMEOUT);
            if (!s_wready) report_timeout("s_wready");
        end
        s_wvalid <= 1'b0;
    endtask

    // m_awvalid comes after beat len+1, or after beat DEPTH on a long burst
    task automatic watch_aw(axi_id_t id, axi_addr_t addr, axi_len_t len, int mode);
        int accepted;
        int expect_beats;
        int t;
        accepted = 0;
        expect_beats = (int'(len) + 1 < DEPTH) ? int'(len) + 1 : DEPTH;
        t = 0;
        while (t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (m_awvalid) break;
            if (s_wvalid && s_wready) accepted++;
            // random stalls so a raised m_awvalid may have to hold
            if (mode == 2) m_awready <= ($urandom_range(1, 0) == 1);
        end
        if (!m_awvalid) begin
            report_timeout("m_awvalid");
        end else begin
            check_value("s_w beats accepted before m_awvalid", 64'(accepted), 64'(expect_beats));
            t = 0;
            while (!m_awready && t < TIMEOUT) begin
                m_awready <= ($urandom_range(1, 0) == 1);
                @(posedge clk);
                t++;
            end
            if (!m_awready) begin
                report_timeout("m_aw transfer");
            end else begin
                check_value("m_awid", 64'(m_awid), 64'(id));
                check_value("m_awaddr", 64'(m_awaddr), 64'(addr));
                check_value("m_awlen", 64'(m_awlen), 64'(len));
            end
        end
        m_awready <= 1'b1;
    endtask

    // mode 0 always ready, 1 held off until m_awvalid, 2 random stalls
    task automatic collect_w(axi_addr_t addr, axi_len_t len, int mode);
        w_beat_t b;
        logic aw_seen;
        int got;
        int t;
        aw_seen = 1'b0;
        got = 0;
        t = 0;
        while (got <= int'(len) && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (m_wvalid && m_wready) begin
                b = w_pattern(addr, got, len);
                check_value("m_wdata", 64'(m_wdata), 64'(b.data));
                check_value("m_wstrb", 64'(m_wstrb), 64'(b.strb));
                check_value("m_wlast", 64'(m_wlast), 64'(b.last));
                got++;
            end
            if (m_awvalid) aw_seen = 1'b1;
            if (mode == 1 && !aw_seen) begin
                m_wready <= 1'b0;
            end else if (mode == 2) begin
                m_wready <= ($urandom_range(3, 0) != 0);
            end else begin
                m_wready <= 1'b1;
            end
        end
        if (got <= int'(len)) report_timeout("m_w beats");
        m_wready <= 1'b1;
    endtask

    task automatic write_burst(axi_id_t id, axi_addr_t addr, axi_len_t len, int mode);
        @(posedge clk);
        m_wready <= (mode != 1);
        fork
            drive_write(id, addr, len);
            watch_aw(id, addr, len, mode);
            collect_w(addr, len, mode);
        join
    endtask

    task automatic write_stream_test();
        axi_len_t lens [5];
        lens = '{8'd2, 8'd7, 8'd0, 8'd9, 8'd4};
        for (int k = 0; k < 5; k++) begin
            write_burst(ID_W'(48 + k), 32'h1000_1000 + 32'(k * 64), lens[k], 2);
        end
        // nothing left behind in the write FIFO
        repeat (6) begin
            @(posedge clk);
            check_value("m_wvalid after stream", 64'(m_wvalid), 64'd0);
        end
    endtask

    task automatic drive_reads();
        int t;
        for (int k = 0; k < 2; k++) begin
            s_arid    <= ID_W'(64 + k);
            s_araddr  <= 32'h2000_0000 + 32'(k * 256);
            s_arlen   <= LEN_W'(RD_LEN);
            s_arvalid <= 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!s_arready && t < TIMEOUT);
            if (!s_arready) report_timeout("s_arready");
        end
        s_arvalid <= 1'b0;
    endtask

    // downstream subordinate, returns each burst in order after its AR
    task automatic serve_reads();
        r_beat_t b;
        int issued;
        int sent;
        int consumed;
        int t;
        issued = 0;
        sent = 0;
        consumed = 0;
        t = 0;
        while ((issued < 2 || sent < 2 * (RD_LEN + 1)) && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            // second request must not even show before its space is free
            if (m_arvalid && issued == 1) begin
                check_value("s_r beats taken before second m_arvalid",
                            64'(consumed >= 4), 64'd1);
            end
            if (m_arvalid && m_arready) begin
                check_value("m_arid", 64'(m_arid), 64'(64 + issued));
                check_value("m_araddr", 64'(m_araddr), 64'(32'h2000_0000 + 32'(issued * 256)));
                check_value("m_arlen", 64'(m_arlen), 64'(RD_LEN));
                issued++;
            end
            if (m_rvalid && m_rready) sent++;
            if (s_rvalid && s_rready) consumed++;
            if (sent < issued * (RD_LEN + 1)) begin
                b = r_pattern(sent / (RD_LEN + 1), sent % (RD_LEN + 1));
                m_rdata  <= b.data;
                m_rlast  <= b.last;
                m_rid    <= b.id;
                m_rresp  <= b.resp;
                m_rvalid <= 1'b1;
            end else begin
                m_rvalid <= 1'b0;
            end
            m_arready <= ($urandom_range(1, 0) == 1);
        end
        if (issued < 2 || sent < 2 * (RD_LEN + 1)) report_timeout("m_ar requests");
        m_rvalid  <= 1'b0;
        m_arready <= 1'b1;
    endtask

    task automatic consume_reads();
        r_beat_t b;
        int got;
        int t;
        got = 0;
        t = 0;
        while (got < 2 * (RD_LEN + 1) && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (s_rvalid && s_rready) begin
                b = r_pattern(got / (RD_LEN + 1), got % (RD_LEN + 1));
                check_value("s_rdata", 64'(s_rdata), 64'(b.data));
                check_value("s_rid", 64'(s_rid), 64'(b.id));
                check_value("s_rresp", 64'(s_rresp), 64'(b.resp));
                check_value("s_rlast", 64'(s_rlast), 64'(b.last));
                got++;
            end
            if (t < RD_HOLD) begin
                s_rready <= 1'b0;
            end else begin
                s_rready <= ($urandom_range(3, 0) != 0);
            end
        end
        if (got < 2 * (RD_LEN + 1)) report_timeout("s_r beats");
        s_rready <= 1'b0;
    endtask

    task automatic read_test();
        @(posedge clk);
        s_rready <= 1'b0;
        fork
            drive_reads();
            serve_reads();
            consume_reads();
        join
    endtask

    task automatic b_passthrough_test();
        axi_id_t   id;
        axi_resp_t resp;
        logic      valid;
        logic      ready;
        id = '0;
        resp = '0;
        valid = 1'b0;
        ready = 1'b0;
        for (int n = 0; n < 10; n++) begin
            @(posedge clk);
            check_value("s_bid", 64'(s_bid), 64'(id));
            check_value("s_bresp", 64'(s_bresp), 64'(resp));
            check_value("s_bvalid", 64'(s_bvalid), 64'(valid));
            check_value("m_bready", 64'(m_bready), 64'(ready));
            id = ID_W'($urandom);
            resp = RESP_W'($urandom);
            valid = ($urandom_range(1, 0) == 1);
            ready = ($urandom_range(1, 0) == 1);
            m_bid    <= id;
            m_bresp  <= resp;
            m_bvalid <= valid;
            s_bready <= ready;
        end
    endtask

    initial begin
        void'($urandom(32'h52b7_e0c2));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        s_awid = '0;
        s_awaddr = '0;
        s_awlen = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wlast = 1'b0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_arid = '0;
        s_araddr = '0;
        s_arlen = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        m_awready = 1'b1;
        m_wready = 1'b1;
        m_bid = '0;
        m_bresp = '0;
        m_bvalid = 1'b0;
        m_arready = 1'b1;
        m_rid = '0;
        m_rdata = '0;
        m_rresp = '0;
        m_rlast = 1'b0;
        m_rvalid = 1'b0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        check_reset();
        write_burst(8'h11, 32'h1000_0040, 8'd3, 0);
        // longer than the write FIFO, released once it fills
        write_burst(8'h22, 32'h1000_0400, 8'd11, 1);
        write_stream_test();
        read_test();
        b_passthrough_test();

        violations = int'(dut_i.assertions_i.violations);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, violations);
        if (errors == 0 && violations == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim/axi_fifo_assertions.sv
`timescale 1ns/1ns

// axi_fifo_assertions
// a raised valid and its payload hold until the transfer on the
// buffered channels of the burst buffer
module axi_fifo_assertions (
    input logic                    clk,
    input logic                    rst,
    input axi_fifo_pkg::axi_id_t   m_awid,
    input axi_fifo_pkg::axi_addr_t m_awaddr,
    input axi_fifo_pkg::axi_len_t  m_awlen,
    input logic                    m_awvalid,
    input logic                    m_awready,
    input axi_fifo_pkg::axi_data_t m_wdata,
    input axi_fifo_pkg::axi_strb_t m_wstrb,
    input logic                    m_wlast,
    input logic                    m_wvalid,
    input logic                    m_wready,
    input axi_fifo_pkg::axi_id_t   m_arid,
    input axi_fifo_pkg::axi_addr_t m_araddr,
    input axi_fifo_pkg::axi_len_t  m_arlen,
    input logic                    m_arvalid,
    input logic                    m_arready,
    input axi_fifo_pkg::axi_id_t   s_rid,
    input axi_fifo_pkg::axi_data_t s_rdata,
    input axi_fifo_pkg::axi_resp_t s_rresp,
    input logic                    s_rlast,
    input logic                    s_rvalid,
    input logic                    s_rready
);

    // read back by the testbench at the end of the run
    int unsigned violations = 0;

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        m_awvalid && !m_awready |=> m_awvalid && $stable({m_awid, m_awaddr, m_awlen}))
        else begin
            violations++;
            $error("m_aw valid or header changed before its transfer");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        m_wvalid && !m_wready |=> m_wvalid && $stable({m_wdata, m_wstrb, m_wlast}))
        else begin
            violations++;
            $error("m_w valid or beat changed before its transfer");
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable({m_arid, m_araddr, m_arlen}))
        else begin
            violations++;
            $error("m_ar valid or header changed before its transfer");
        end

    // upstream read beat waits for s_rready
    r_hold: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable({s_rid, s_rdata, s_rresp, s_rlast}))
        else begin
            violations++;
            $error("s_r valid or beat changed before its transfer");
        end

endmodule

bind axi_fifo axi_fifo_assertions assertions_i (.*);

//--- rtl/axi_fifo.sv
`timescale 1ns/1ns

// axi_fifo
// AXI4 burst buffer between an upstream manager and a downstream
// subordinate: write data FIFO with delayed AW release, read data
// FIFO with AR space reservation, B channel passed straight through
module axi_fifo #(
    parameter int WRITE_FIFO_DEPTH = 32,
    parameter int READ_FIFO_DEPTH  = 32
) (
    input  logic                    clk,
    input  logic                    rst,

    // upstream side
    input  axi_fifo_pkg::axi_id_t   s_awid,
    input  axi_fifo_pkg::axi_addr_t s_awaddr,
    input  axi_fifo_pkg::axi_len_t  s_awlen,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  axi_fifo_pkg::axi_data_t s_wdata,
    input  axi_fifo_pkg::axi_strb_t s_wstrb,
    input  logic                    s_wlast,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output axi_fifo_pkg::axi_id_t   s_bid,
    output axi_fifo_pkg::axi_resp_t s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  axi_fifo_pkg::axi_id_t   s_arid,
    input  axi_fifo_pkg::axi_addr_t s_araddr,
    input  axi_fifo_pkg::axi_len_t  s_arlen,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output axi_fifo_pkg::axi_id_t   s_rid,
    output axi_fifo_pkg::axi_data_t s_rdata,
    output axi_fifo_pkg::axi_resp_t s_rresp,
    output logic                    s_rlast,
    output logic                    s_rvalid,
    input  logic                    s_rready,

    // downstream side
    output axi_fifo_pkg::axi_id_t   m_awid,
    output axi_fifo_pkg::axi_addr_t m_awaddr,
    output axi_fifo_pkg::axi_len_t  m_awlen,
    output logic                    m_awvalid,
    input  logic                    m_awready,
    output axi_fifo_pkg::axi_data_t m_wdata,
    output axi_fifo_pkg::axi_strb_t m_wstrb,
    output logic                    m_wlast,
    output logic                    m_wvalid,
    input  logic                    m_wready,
    input  axi_fifo_pkg::axi_id_t   m_bid,
    input  axi_fifo_pkg::axi_resp_t m_bresp,
    input  logic                    m_bvalid,
    output logic                    m_bready,
    output axi_fifo_pkg::axi_id_t   m_arid,
    output axi_fifo_pkg::axi_addr_t m_araddr,
    output axi_fifo_pkg::axi_len_t  m_arlen,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  axi_fifo_pkg::axi_id_t   m_rid,
    input  axi_fifo_pkg::axi_data_t m_rdata,
    input  axi_fifo_pkg::axi_resp_t m_rresp,
    input  logic                    m_rlast,
    input  logic                    m_rvalid,
    output logic                    m_rready
);

    import axi_fifo_pkg::*;

    w_beat_t w_in;
    w_beat_t w_out;
    r_beat_t r_in;
    r_beat_t r_out;

    logic w_push_valid;
    logic w_fifo_ready;
    logic r_taken;

    // write path
    aw_release #(
        .DEPTH(WRITE_FIFO_DEPTH)
    ) aw_release_i (
        .clk       (clk),
        .rst       (rst),
        .s_awid    (s_awid),
        .s_awaddr  (s_awaddr),
        .s_awlen   (s_awlen),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .m_awid    (m_awid),
        .m_awaddr  (m_awaddr),
        .m_awlen   (m_awlen),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .s_wvalid  (s_wvalid),
        .fifo_ready(w_fifo_ready),
        .push_valid(w_push_valid),
        .s_wready  (s_wready)
    );

    assign w_in.data = s_wdata;
    assign w_in.strb = s_wstrb;
    assign w_in.last = s_wlast;

    beat_fifo #(
        .DEPTH (WRITE_FIFO_DEPTH),
        .beat_t(w_beat_t)
    ) w_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (w_in),
        .in_valid (w_push_valid),
        .in_ready (w_fifo_ready),
        .out_data (w_out),
        .out_valid(m_wvalid),
        .out_ready(m_wready)
    );

    assign m_wdata = w_out.data;
    assign m_wstrb = w_out.strb;
    assign m_wlast = w_out.last;

    // read path
    assign r_taken = s_rvalid && s_rready;

    ar_reserve #(
        .DEPTH(READ_FIFO_DEPTH)
    ) ar_reserve_i (
        .clk      (clk),
        .rst      (rst),
        .s_arid   (s_arid),
        .s_araddr (s_araddr),
        .s_arlen  (s_arlen),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .m_arid   (m_arid),
        .m_araddr (m_araddr),
        .m_arlen  (m_arlen),
        .m_arvalid(m_arvalid),
        .m_arready(m_arready),
        .r_taken  (r_taken)
    );

    assign r_in.data = m_rdata;
    assign r_in.last = m_rlast;
    assign r_in.id   = m_rid;
    assign r_in.resp = m_rresp;

    beat_fifo #(
        .DEPTH (READ_FIFO_DEPTH),
        .beat_t(r_beat_t)
    ) r_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (r_in),
        .in_valid (m_rvalid),
        .in_ready (m_rready),
        .out_data (r_out),
        .out_valid(s_rvalid),
        .out_ready(s_rready)
    );

    assign s_rdata = r_out.data;
    assign s_rlast = r_out.last;
    assign s_rid   = r_out.id;
    assign s_rresp = r_out.resp;

    // write response straight through
    assign s_bid    = m_bid;
    assign s_bresp  = m_bresp;
    assign s_bvalid = m_bvalid;
    assign m_bready = s_bready;

endmodule

//--- rtl/ar_reserve.sv
`timescale 1ns/1ns

// ar_reserve
// issues a read address only when the read FIFO can take the whole
// burst, or when nothing is outstanding; one slot returns per R beat
module ar_reserve #(
    parameter int DEPTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_fifo_pkg::axi_id_t   s_arid,
    input  axi_fifo_pkg::axi_addr_t s_araddr,
    input  axi_fifo_pkg::axi_len_t  s_arlen,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output axi_fifo_pkg::axi_id_t   m_arid,
    output axi_fifo_pkg::axi_addr_t m_araddr,
    output axi_fifo_pkg::axi_len_t  m_arlen,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  logic                    r_taken
);

    import axi_fifo_pkg::*;

    localparam int AW    = $clog2(DEPTH);
    // a single burst may exceed the FIFO when it is admitted empty
    localparam int CNT_W = ((AW > LEN_W) ? AW : LEN_W) + 1;
    localparam int SUM_W = CNT_W + 1;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t           state_q;
    state_t           state_d;
    logic             arready_q;
    logic             arready_d;
    logic             arvalid_q;
    logic             arvalid_d;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;

    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;

    axi_len_t         len_sel;
    logic [SUM_W-1:0] need;
    logic             accept_ar;
    logic             fits;

    assign accept_ar = s_arvalid && arready_q;

    // new request is checked on accept, a held one while waiting
    assign len_sel = (state_q == ST_IDLE) ? s_arlen : len_q;
    assign need    = SUM_W'(count_q) + SUM_W'(len_sel) + SUM_W'(1);
    assign fits    = (count_q == '0) || (need <= SUM_W'(DEPTH));

    always_comb begin
        state_d   = state_q;
        arready_d = arready_q;
        arvalid_d = arvalid_q && !m_arready;
        count_d   = count_q;
        case (state_q)
            ST_IDLE: begin
                arready_d = !arvalid_q;
                if (accept_ar) begin
                    arready_d = 1'b0;
                    if (fits) begin
                        count_d   = need[CNT_W-1:0];
                        arvalid_d = 1'b1;
                    end else begin
                        state_d = ST_WAIT;
                    end
                end
            end
            ST_WAIT: begin
                if (fits) begin
                    count_d   = need[CNT_W-1:0];
                    arvalid_d = 1'b1;
                    state_d   = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
        // delivered beat frees its slot
        if (r_taken) begin
            count_d = count_d - CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            arready_q <= 1'b0;
            arvalid_q <= 1'b0;
            count_q   <= '0;
        end else begin
            state_q   <= state_d;
            arready_q <= arready_d;
            arvalid_q <= arvalid_d;
            count_q   <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_ar) begin
            id_q   <= s_arid;
            addr_q <= s_araddr;
            len_q  <= s_arlen;
        end
    end

    assign s_arready = arready_q;
    assign m_arvalid = arvalid_q;
    assign m_arid    = id_q;
    assign m_araddr  = addr_q;
    assign m_arlen   = len_q;

endmodule

//--- rtl/aw_release.sv
`timescale 1ns/1ns

// aw_release
// holds a write address until its burst is in the write FIFO, or
// until the FIFO has filled on a burst longer than the FIFO
module aw_release #(
    parameter int DEPTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_fifo_pkg::axi_id_t   s_awid,
    input  axi_fifo_pkg::axi_addr_t s_awaddr,
    input  axi_fifo_pkg::axi_len_t  s_awlen,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    output axi_fifo_pkg::axi_id_t   m_awid,
    output axi_fifo_pkg::axi_addr_t m_awaddr,
    output axi_fifo_pkg::axi_len_t  m_awlen,
    output logic                    m_awvalid,
    input  logic                    m_awready,
    input  logic                    s_wvalid,
    input  logic                    fifo_ready,
    output logic                    push_valid,
    output logic                    s_wready
);

    import axi_fifo_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_DRAIN
    } state_t;

    state_t         state_q;
    state_t         state_d;
    logic           open_q;
    logic           open_d;
    logic           awready_q;
    logic           awready_d;
    logic           awvalid_q;
    logic           awvalid_d;
    logic [LEN_W:0] count_q;
    logic [LEN_W:0] count_d;

    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;

    logic accept_aw;
    logic accept_w;
    logic last_beat;
    logic filled;

    // W beats pass only while a burst window is open
    assign s_wready   = fifo_ready && open_q;
    assign push_valid = s_wvalid && open_q;

    assign accept_aw = s_awvalid && awready_q;
    assign accept_w  = s_wvalid && s_wready;
    assign last_beat = (count_q == {1'b0, len_q});
    // this beat brings the burst up to the FIFO depth
    assign filled    = (32'(count_q) + 32'd1 == 32'(DEPTH));

    always_comb begin
        state_d   = state_q;
        open_d    = open_q;
        awready_d = awready_q;
        awvalid_d = awvalid_q && !m_awready;
        count_d   = count_q;
        case (state_q)
            ST_IDLE: begin
                awready_d = !awvalid_q;
                if (accept_aw) begin
                    awready_d = 1'b0;
                    open_d    = 1'b1;
                    count_d   = '0;
                    state_d   = ST_COLLECT;
                end
            end
            ST_COLLECT: begin
                if (accept_w) begin
                    count_d = count_q + (LEN_W+1)'(1);
                    if (last_beat) begin
                        awvalid_d = 1'b1;
                        open_d    = 1'b0;
                        state_d   = ST_IDLE;
                    end else if (filled) begin
                        // release early, rest of the burst streams through
                        awvalid_d = 1'b1;
                        state_d   = ST_DRAIN;
                    end
                end
            end
            ST_DRAIN: begin
                if (accept_w) begin
                    count_d = count_q + (LEN_W+1)'(1);
                    if (last_beat) begin
                        open_d  = 1'b0;
                        state_d = ST_IDLE;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            open_q    <= 1'b0;
            awready_q <= 1'b0;
            awvalid_q <= 1'b0;
            count_q   <= '0;
        end else begin
            state_q   <= state_d;
            open_q    <= open_d;
            awready_q <= awready_d;
            awvalid_q <= awvalid_d;
            count_q   <= count_d;
        end
    end

    // captured header
    always_ff @(posedge clk) begin
        if (accept_aw) begin
            id_q   <= s_awid;
            addr_q <= s_awaddr;
            len_q  <= s_awlen;
        end
    end

    assign s_awready = awready_q;
    assign m_awvalid = awvalid_q;
    assign m_awid    = id_q;
    assign m_awaddr  = addr_q;
    assign m_awlen   = len_q;

endmodule

//--- rtl/beat_fifo.sv
`timescale 1ns/1ns

// beat_fifo
// beat buffer generic over its payload type, with a registered memory
// write, a registered memory read and an output register
// holds DEPTH beats in memory plus two in the read pipeline
module beat_fifo #(
    parameter int DEPTH = 32,
    parameter type beat_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst,
    input  beat_t in_data,
    input  logic  in_valid,
    output logic  in_ready,
    output beat_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int AW = $clog2(DEPTH);

    beat_t mem [DEPTH];

    // pointers carry one extra wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] wr_ptr_done;
    logic [AW:0] rd_ptr;

    // pending memory write
    logic          wr_en_q;
    logic [AW-1:0] wr_addr_q;
    beat_t         wr_data_q;

    beat_t rd_data_q;
    logic  rd_valid_q;

    logic full;
    logic empty;
    logic push;
    logic pop;
    logic store;

    // full counts beats still waiting in the write stage
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    // read side only sees beats already in memory
    assign empty = (wr_ptr_done == rd_ptr);

    assign in_ready = !full;
    assign push = in_valid && !full;

    // output register is free or being taken
    assign store = out_ready || !out_valid;
    assign pop = (store || !rd_valid_q) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            wr_ptr_done <= '0;
            wr_en_q     <= 1'b0;
        end else begin
            wr_ptr_done <= wr_ptr;
            wr_en_q     <= push;
            if (push) begin
                wr_ptr <= wr_ptr + (AW+1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr     <= '0;
            rd_valid_q <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + (AW+1)'(1);
            end
            if (store || !rd_valid_q) begin
                rd_valid_q <= !empty;
            end
            if (store) begin
                out_valid <= rd_valid_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_q) begin
            mem[wr_addr_q] <= wr_data_q;
        end
    end

    // payload stages
    always_ff @(posedge clk) begin
        if (push) begin
            wr_addr_q <= wr_ptr[AW-1:0];
            wr_data_q <= in_data;
        end
        if (pop) begin
            rd_data_q <= mem[rd_ptr[AW-1:0]];
        end
        if (store) begin
            out_data <= rd_data_q;
        end
    end

endmodule

//--- rtl/axi_fifo_pkg.sv
// axi burst buffer shared definitions
// field widths, channel field types and the two beat payloads
// carried by the write and read data FIFOs
package axi_fifo_pkg;

    // channel field widths
    localparam int ID_W   = 8;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    // burst length is beats minus one
    localparam int LEN_W  = 8;
    localparam int RESP_W = 2;

    typedef logic [ID_W-1:0]   axi_id_t;
    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [LEN_W-1:0]  axi_len_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [STRB_W-1:0] axi_strb_t;
    typedef logic [RESP_W-1:0] axi_resp_t;

    // one W channel beat
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } w_beat_t;

    // one R channel beat
    typedef struct packed {
        axi_data_t data;
        logic      last;
        axi_id_t   id;
        axi_resp_t resp;
    } r_beat_t;

endpackage
